// ==== Makefile ====
# Verilator build and run of the ifmap SRAM writer testbench

VERILATOR ?= verilator
TOP       ?= ifmap_sram_writer_tb
FILELIST  ?= ifmap_sram_writer.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= sim passed
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "test FAILED, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== ifmap_sram_writer.f ====
rtl/ifw_pkg.sv
rtl/ifw_tap_delay.sv
rtl/ifw_stream_counter.sv
rtl/ifw_bank_writer.sv
rtl/ifw_job_ctrl.sv
rtl/ifmap_sram_writer.sv
verification/ifmap_sram_writer_asserts.sv
verification/ifmap_sram_writer_tb.sv

// ==== rtl/ifmap_sram_writer.sv ====
`timescale 1ns/1ps

module ifmap_sram_writer #(
	parameter int NUM_BUF      = ifw_pkg::DEF_NUM_BUF,
	parameter int CH_WORDS     = ifw_pkg::DEF_CH_WORDS,
	parameter int KERNEL       = ifw_pkg::DEF_KERNEL,
	parameter int COLS_PER_BUF = ifw_pkg::DEF_COLS_PER_BUF,
	parameter int ROWS         = ifw_pkg::DEF_ROWS
) (
	input  logic           clk,
	input  logic           reset,
	input  logic           start_store,
	input  logic           fifo_empty_n,
	input  ifw_pkg::word_t fifo_data,
	output logic           fifo_read,
	output logic           store_busy,
	output logic           store_done,
	output logic           bank_cen  [NUM_BUF],
	output logic           bank_wen  [NUM_BUF],
	output ifw_pkg::addr_t bank_addr [NUM_BUF],
	output ifw_pkg::word_t bank_data [NUM_BUF]
);
	import ifw_pkg::*;

	word_t      word;
	din_index_t index;
	flag_t      flags;

	word_t      word_tap  [NUM_BUF];	// tap b feeds bank b
	din_index_t index_tap [NUM_BUF];
	flag_t      flag_tap  [NUM_BUF];

	logic       finished [NUM_BUF];
	logic       clear;	// one cycle, end of job

	// ------------------------------
	// input stream
	// ------------------------------
	ifw_stream_counter #(
		.CH_WORDS     (CH_WORDS),
		.NUM_BUF      (NUM_BUF),
		.COLS_PER_BUF (COLS_PER_BUF),
		.KERNEL       (KERNEL),
		.ROWS         (ROWS)
	) u_stream (
		.clk          (clk),
		.reset        (reset),
		.clear        (clear),
		.busy         (store_busy),
		.fifo_empty_n (fifo_empty_n),
		.fifo_data    (fifo_data),
		.fifo_read    (fifo_read),
		.word         (word),
		.index        (index),
		.flags        (flags)
	);

	// one cycle more per bank
	ifw_tap_delay #(.payload_t(word_t), .DEPTH(NUM_BUF)) u_word_dly (
		.clk  (clk),
		.din  (word),
		.taps (word_tap)
	);

	ifw_tap_delay #(.payload_t(din_index_t), .DEPTH(NUM_BUF)) u_index_dly (
		.clk  (clk),
		.din  (index),
		.taps (index_tap)
	);

	ifw_tap_delay #(.payload_t(flag_t), .DEPTH(NUM_BUF)) u_flag_dly (
		.clk  (clk),
		.din  (flags),
		.taps (flag_tap)
	);

	// ------------------------------
	// bank writers
	// ------------------------------
	for (genvar b = 0; b < NUM_BUF; b++) begin : g_bank
		ifw_bank_writer #(
			.BUF_ID       (b),
			.CH_WORDS     (CH_WORDS),
			.NUM_BUF      (NUM_BUF),
			.KERNEL       (KERNEL),
			.COLS_PER_BUF (COLS_PER_BUF)
		) u_writer (
			.clk      (clk),
			.reset    (reset),
			.clear    (clear),
			.word     (word_tap[b]),
			.index    (index_tap[b]),
			.flags    (flag_tap[b]),
			.cen      (bank_cen[b]),
			.wen      (bank_wen[b]),
			.addr     (bank_addr[b]),
			.data     (bank_data[b]),
			.finished (finished[b])
		);
	end

	// last bank is the last one to finish a job
	ifw_job_ctrl u_ctrl (
		.clk           (clk),
		.reset         (reset),
		.start_store   (start_store),
		.bank_finished (finished[NUM_BUF-1]),
		.busy          (store_busy),
		.clear         (clear),
		.done          (store_done)
	);

endmodule

// ==== rtl/ifw_bank_writer.sv ====
`timescale 1ns/1ps

module ifw_bank_writer #(
	parameter int BUF_ID       = 0,
	parameter int CH_WORDS     = ifw_pkg::DEF_CH_WORDS,
	parameter int NUM_BUF      = ifw_pkg::DEF_NUM_BUF,
	parameter int KERNEL       = ifw_pkg::DEF_KERNEL,
	parameter int COLS_PER_BUF = ifw_pkg::DEF_COLS_PER_BUF
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                clear,
	input  ifw_pkg::word_t      word,
	input  ifw_pkg::din_index_t index,
	input  ifw_pkg::flag_t      flags,
	output logic                cen,
	output logic                wen,
	output ifw_pkg::addr_t      addr,
	output ifw_pkg::word_t      data,
	output logic                finished
);
	import ifw_pkg::*;

	// ------------------------------
	// window geometry
	// ------------------------------
	localparam int WIN_WORDS  = KERNEL * CH_WORDS;	// words in one kernel window
	localparam int COL_STRIDE = NUM_BUF * CH_WORDS;	// next window of this bank
	localparam int BASE       = BUF_ID * CH_WORDS;	// first window start
	localparam int WIN_W      = $clog2(WIN_WORDS + 1);
	localparam int COL_W      = $clog2(COLS_PER_BUF + 1);

	logic [WIN_W-1:0] win_cnt;	// word inside the window
	logic [COL_W-1:0] col_cnt;	// window inside the row
	din_index_t       col_start;
	din_index_t       target;
	logic             write;
	logic             win_last;
	logic             col_last;

	assign col_start = din_index_t'(BASE) + din_index_t'(COL_STRIDE) * din_index_t'(col_cnt);
	assign target    = col_start + din_index_t'(win_cnt);

	assign win_last = win_cnt == WIN_W'(WIN_WORDS - 1);
	assign col_last = col_cnt == COL_W'(COLS_PER_BUF - 1);

	// capture when the stream reaches our next position
	assign write = flags.valid & ~finished & (index == target);

	// ------------------------------
	// counters
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset || clear) begin
			win_cnt <= '0;
			col_cnt <= '0;
		end else if (write) begin
			if (win_last) begin
				win_cnt <= '0;
				col_cnt <= col_last ? '0 : col_cnt + 1'b1;
			end else begin
				win_cnt <= win_cnt + 1'b1;
			end
		end
	end

	// sram address, one per captured word
	always_ff @(posedge clk) begin
		if (reset || clear) begin
			addr <= '0;
		end else if (write) begin
			addr <= addr + 1'b1;
		end
	end

	// final window of the final row written
	always_ff @(posedge clk) begin
		if (reset || clear) begin
			finished <= 1'b0;
		end else if (write && win_last && col_last && flags.last_row) begin
			finished <= 1'b1;
		end
	end

	// ------------------------------
	// sram port
	// ------------------------------
	assign cen  = ~write;	// active low
	assign wen  = ~write;
	assign data = word;

endmodule

// ==== rtl/ifw_job_ctrl.sv ====
`timescale 1ns/1ps

module ifw_job_ctrl (
	input  logic clk,
	input  logic reset,
	input  logic start_store,
	input  logic bank_finished,
	output logic busy,
	output logic clear,
	output logic done
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_RUN,
		S_CLEAR,	// resets every counter for the next job
		S_DONE
	} state_t;

	state_t state;
	state_t state_next;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			S_IDLE:  if (start_store) state_next = S_RUN;
			S_RUN:   if (bank_finished) state_next = S_CLEAR;
			S_CLEAR: state_next = S_DONE;
			S_DONE:  state_next = S_IDLE;
			default: state_next = S_IDLE;
		endcase
	end

	// ------------------------------
	// status
	// ------------------------------
	assign busy  = state != S_IDLE;	// through clear and done too
	assign clear = state == S_CLEAR;
	assign done  = state == S_DONE;

endmodule

// ==== rtl/ifw_pkg.sv ====
package ifw_pkg;

	// ------------------------------
	// word, address and index widths
	// ------------------------------
	localparam int DATA_W      = 64;	// fifo and sram word
	localparam int SRAM_ADDR_W = 11;	// 2k words per bank
	localparam int DIN_INDEX_W = 9;	// rows up to 512 words

	typedef logic [DATA_W-1:0]      word_t;
	typedef logic [SRAM_ADDR_W-1:0] addr_t;
	typedef logic [DIN_INDEX_W-1:0] din_index_t;

	// per-word flags, delayed together with the word
	typedef struct packed {
		logic valid;
		logic last_row;
	} flag_t;

	// ------------------------------
	// default geometry
	// ------------------------------
	localparam int DEF_NUM_BUF      = 4;	// sram banks
	localparam int DEF_CH_WORDS     = 2;	// words per pixel, all channels
	localparam int DEF_KERNEL       = 3;
	localparam int DEF_COLS_PER_BUF = 2;	// output columns per bank
	localparam int DEF_ROWS         = 3;	// input rows per job

endpackage

// ==== rtl/ifw_stream_counter.sv ====
`timescale 1ns/1ps

module ifw_stream_counter #(
	parameter int CH_WORDS     = ifw_pkg::DEF_CH_WORDS,
	parameter int NUM_BUF      = ifw_pkg::DEF_NUM_BUF,
	parameter int COLS_PER_BUF = ifw_pkg::DEF_COLS_PER_BUF,
	parameter int KERNEL       = ifw_pkg::DEF_KERNEL,
	parameter int ROWS         = ifw_pkg::DEF_ROWS
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                clear,
	input  logic                busy,
	input  logic                fifo_empty_n,
	input  ifw_pkg::word_t      fifo_data,
	output logic                fifo_read,
	output ifw_pkg::word_t      word,
	output ifw_pkg::din_index_t index,
	output ifw_pkg::flag_t      flags
);
	import ifw_pkg::*;

	localparam int ROW_WORDS = CH_WORDS * (NUM_BUF * COLS_PER_BUF + KERNEL - 1);
	localparam int ROW_W     = $clog2(ROWS + 1);

	logic             valid_word;
	logic             row_end;	// word at the last row position
	logic             last_row;
	logic             job_end;	// final word of the job taken now
	logic             stream_end;	// held until the job goes idle
	logic [ROW_W-1:0] row_cnt;

	assign valid_word = fifo_read & fifo_empty_n;
	assign row_end    = index == din_index_t'(ROW_WORDS - 1);
	assign last_row   = row_cnt == ROW_W'(ROWS - 1);
	assign job_end    = valid_word & row_end & last_row;

	// ------------------------------
	// read strobe
	// ------------------------------
	// stops after the final word so the next job's data stays in the fifo
	always_ff @(posedge clk) begin
		if (reset) begin
			fifo_read <= 1'b0;
		end else begin
			fifo_read <= busy & fifo_empty_n & ~stream_end & ~job_end;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || !busy) begin
			stream_end <= 1'b0;
		end else if (job_end) begin
			stream_end <= 1'b1;
		end
	end

	// ------------------------------
	// in-row index and row counter
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset || clear) begin
			index   <= '0;
			row_cnt <= '0;
		end else if (valid_word) begin
			if (row_end) begin
				index   <= '0;
				row_cnt <= last_row ? '0 : row_cnt + 1'b1;	// wrap after last row
			end else begin
				index <= index + 1'b1;
			end
		end
	end

	assign word           = fifo_data;
	assign flags.valid    = valid_word;
	assign flags.last_row = last_row;

endmodule

// ==== rtl/ifw_tap_delay.sv ====
`timescale 1ns/1ps

module ifw_tap_delay #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 1
) (
	input  logic     clk,
	input  payload_t din,
	output payload_t taps [DEPTH]
);

	// tap i is i+1 cycles behind din
	always_ff @(posedge clk) begin
		taps[0] <= din;
		for (int i = 1; i < DEPTH; i++) begin
			taps[i] <= taps[i-1];
		end
	end

endmodule

// ==== verification/ifmap_sram_writer_asserts.sv ====
`timescale 1ns/1ps

module ifmap_sram_writer_asserts #(
	parameter int NUM_BUF = 4
) (
	input logic clk,
	input logic reset,
	input logic fifo_read,
	input logic store_busy,
	input logic store_done,
	input logic bank_cen [NUM_BUF],
	input logic bank_wen [NUM_BUF]
);

	// ------------------------------
	// job control
	// ------------------------------
	a_done_pulse: assert property (@(posedge clk) disable iff (reset)
		store_done |=> !store_done)
		else $error("store_done held longer than one cycle");

	a_done_busy: assert property (@(posedge clk) disable iff (reset)
		store_done |-> store_busy)
		else $error("store_done high while store_busy is low");

	// no fifo reads outside a job
	a_read_idle: assert property (@(posedge clk) disable iff (reset)
		!store_busy |-> !fifo_read)
		else $error("fifo_read high while store_busy is low");

	// ------------------------------
	// sram strobes
	// ------------------------------
	for (genvar b = 0; b < NUM_BUF; b++) begin : g_bank
		a_cen_wen: assert property (@(posedge clk) bank_cen[b] == bank_wen[b])
			else $error("bank %0d cen and wen differ", b);
	end

endmodule

// ==== verification/ifmap_sram_writer_tb.sv ====
`timescale 1ns/1ps

module ifmap_sram_writer_tb;
	import ifw_pkg::*;

	localparam int NUM_BUF         = DEF_NUM_BUF;
	localparam int ROW_WORDS       = 20;
	localparam int JOB_WORDS       = 60;
	localparam int WRITES_PER_BANK = 36;
	localparam int JOBS            = 2;
	localparam int FIFO_WORDS      = JOBS * JOB_WORDS;	// both jobs queued up front
	localparam int TIMEOUT         = 4 * JOBS * JOB_WORDS + 200;

	logic  clk;
	logic  reset;
	logic  start_store;
	logic  fifo_empty_n;
	word_t fifo_data;
	logic  fifo_read;
	logic  store_busy;
	logic  store_done;
	logic  bank_cen  [NUM_BUF];
	logic  bank_wen  [NUM_BUF];
	addr_t bank_addr [NUM_BUF];
	word_t bank_data [NUM_BUF];

	logic [DATA_W+NUM_BUF-1:0] vectors [JOB_WORDS];	// {bank mask, word}
	word_t  exp_q [NUM_BUF][$];	// expected words per bank
	int     write_cnt [NUM_BUF];	// also the expected address
	int     done_cnt  = 0;
	int     cycle_cnt = 0;
	int     rd_ptr    = 0;
	integer seed;

	ifmap_sram_writer #(
		.NUM_BUF      (NUM_BUF),
		.CH_WORDS     (DEF_CH_WORDS),
		.KERNEL       (DEF_KERNEL),
		.COLS_PER_BUF (DEF_COLS_PER_BUF),
		.ROWS         (DEF_ROWS)
	) u_dut (.*);

	bind ifmap_sram_writer ifmap_sram_writer_asserts #(.NUM_BUF(NUM_BUF)) u_asserts (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic report_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		abort_run($sformatf("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp));
	endtask

	// ------------------------------
	// fifo model with first word fall through
	// ------------------------------
	always @(posedge clk) begin : fifo_model
		int next_ptr;
		next_ptr = rd_ptr + int'(fifo_read && fifo_empty_n);	// word taken this cycle
		if (reset) begin
			next_ptr = 0;
		end
		rd_ptr       <= next_ptr;
		fifo_data    <= vectors[next_ptr % JOB_WORDS][DATA_W-1:0];
		fifo_empty_n <= !reset && next_ptr < FIFO_WORDS && ($random(seed) & 3) != 0;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT) begin
			abort_run($sformatf("timeout after %0d cycles, job did not complete", TIMEOUT));
		end
	end

	// ------------------------------
	// write checks
	// ------------------------------
	always @(negedge clk) begin : write_monitor
		word_t head;
		if (!reset) begin
			for (int b = 0; b < NUM_BUF; b++) begin
				if (!bank_cen[b]) begin
					assert (exp_q[b].size() > 0)
						else abort_run($sformatf("bank %0d wrote more words than expected", b));
					head = exp_q[b].pop_front();
					assert (bank_wen[b] == 1'b0)
						else report_value($sformatf("bank_wen[%0d]", b), 64'(bank_wen[b]),
							64'(0));
					assert (bank_addr[b] == addr_t'(write_cnt[b]))
						else report_value($sformatf("bank_addr[%0d]", b), 64'(bank_addr[b]),
							64'(write_cnt[b]));
					assert (bank_data[b] == head)
						else report_value($sformatf("bank_data[%0d]", b), bank_data[b], head);
					write_cnt[b]++;
				end
			end
			if (store_done) begin
				done_cnt++;
				for (int b = 0; b < NUM_BUF; b++) begin
					assert (write_cnt[b] == WRITES_PER_BANK && exp_q[b].size() == 0)
						else report_value($sformatf("writes to bank %0d", b), 64'(write_cnt[b]),
							64'(WRITES_PER_BANK));
				end
			end
		end
	end

	task automatic check_idle();
		repeat (3) begin
			@(negedge clk);
			assert (fifo_read == 1'b0) else report_value("fifo_read", 64'(fifo_read), 64'(0));
			assert (store_busy == 1'b0) else report_value("store_busy", 64'(store_busy), 64'(0));
			assert (store_done == 1'b0) else report_value("store_done", 64'(store_done), 64'(0));
			for (int b = 0; b < NUM_BUF; b++) begin
				assert (bank_cen[b] && bank_wen[b])
					else abort_run($sformatf("bank %0d strobes active while idle", b));
			end
		end
	endtask

	// masked words in stream order with addresses from 0
	task automatic build_expected();
		for (int b = 0; b < NUM_BUF; b++) begin
			exp_q[b].delete();
			write_cnt[b] = 0;
		end
		for (int i = 0; i < JOB_WORDS; i++) begin
			// every row repeats the window pattern of row 0
			assert (vectors[i][DATA_W +: NUM_BUF] == vectors[i % ROW_WORDS][DATA_W +: NUM_BUF])
				else abort_run($sformatf("vectors file mask of word %0d differs from row 0", i));
			for (int b = 0; b < NUM_BUF; b++) begin
				if (vectors[i][DATA_W+b]) exp_q[b].push_back(vectors[i][DATA_W-1:0]);
			end
		end
		for (int b = 0; b < NUM_BUF; b++) begin
			assert (exp_q[b].size() == WRITES_PER_BANK)
				else abort_run($sformatf("vectors file gives bank %0d a wrong word count", b));
		end
	endtask

	task automatic run_job(input int job);
		build_expected();
		@(posedge clk);
		start_store <= 1'b1;
		@(posedge clk);
		start_store <= 1'b0;
		@(negedge clk);
		assert (store_busy == 1'b1) else report_value("store_busy", 64'(store_busy), 64'(1));
		wait (done_cnt == job + 1);
		@(negedge clk);
		assert (store_busy == 1'b0) else report_value("store_busy", 64'(store_busy), 64'(0));
		assert (store_done == 1'b0) else report_value("store_done", 64'(store_done), 64'(0));
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		seed         = 32'hfeaa547c;
		reset        = 1'b1;
		start_store  = 1'b0;
		fifo_empty_n = 1'b0;
		fifo_data    = '0;
		$readmemh("verification/ifw_vectors.txt", vectors);
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		check_idle();
		for (int job = 0; job < JOBS; job++) begin
			run_job(job);
		end
		repeat (4) @(negedge clk);
		if (done_cnt == JOBS) begin
			$display("sim passed");
			$finish;
		end else begin
			abort_run($sformatf("store_done seen %0d times for %0d jobs", done_cnt, JOBS));
		end
	end

endmodule

// ==== verification/ifw_vectors.txt ====
// one token per line: bank mask (1 hex digit, bit b = bank b) then the 64-bit word
// words in stream order, 3 rows of 20 words
1a50000003c3c0000
1a50000013c3c0001
3a50000023c3c0002
3a50000033c3c0003
7a50000043c3c0004
7a50000053c3c0005
ea50000063c3c0006
ea50000073c3c0007
da50000083c3c0008
da50000093c3c0009
ba500000a3c3c000a
ba500000b3c3c000b
7a500000c3c3c000c
7a500000d3c3c000d
ea500000e3c3c000e
ea500000f3c3c000f
ca50000103c3c0010
ca50000113c3c0011
8a50000123c3c0012
8a50000133c3c0013
1a51000003c3c1000
1a51000013c3c1001
3a51000023c3c1002
3a51000033c3c1003
7a51000043c3c1004
7a51000053c3c1005
ea51000063c3c1006
ea51000073c3c1007
da51000083c3c1008
da51000093c3c1009
ba510000a3c3c100a
ba510000b3c3c100b
7a510000c3c3c100c
7a510000d3c3c100d
ea510000e3c3c100e
ea510000f3c3c100f
ca51000103c3c1010
ca51000113c3c1011
8a51000123c3c1012
8a51000133c3c1013
1a52000003c3c2000
1a52000013c3c2001
3a52000023c3c2002
3a52000033c3c2003
7a52000043c3c2004
7a52000053c3c2005
ea52000063c3c2006
ea52000073c3c2007
da52000083c3c2008
da52000093c3c2009
ba520000a3c3c200a
ba520000b3c3c200b
7a520000c3c3c200c
7a520000d3c3c200d
ea520000e3c3c200e
ea520000f3c3c200f
ca52000103c3c2010
ca52000113c3c2011
8a52000123c3c2012
8a52000133c3c2013
